// File: hw/pc_hard_pkg.sv
// PC hardening shared definitions
`default_nettype none

package pc_hard_pkg;

  // Fetch address width
  localparam int PC_W = 32;

  // Sequential successor steps for compressed and full instructions
  localparam logic [PC_W-1:0] INC_CMPR = 2;
  localparam logic [PC_W-1:0] INC_FULL = 4;

  // Fault record queue sizing
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);
  localparam int FIFO_CW = $clog2(FIFO_DEPTH + 1);
  localparam logic [FIFO_CW-1:0] FIFO_CNT_MAX = FIFO_CW'(FIFO_DEPTH);

  // Credits granted by the alert handler out of reset
  localparam int LOG_CREDITS = 2;
  localparam int CRED_W = $clog2(LOG_CREDITS + 1);
  localparam logic [CRED_W-1:0] CRED_INIT = CRED_W'(LOG_CREDITS);

  // PC mux select codes as seen from the core controller
  typedef enum logic [3:0] {
    PC_MUX_OTHER  = 4'd0,
    PC_MUX_MRET   = 4'd1,
    PC_MUX_JUMP   = 4'd4,
    PC_MUX_BRANCH = 4'd5
  } pc_mux_e;

  typedef enum logic [2:0] {
    FAULT_NONE       = 3'd0,
    FAULT_SEQ        = 3'd1,
    FAULT_BRANCH_TGT = 3'd2,
    FAULT_JUMP_TGT   = 3'd3,
    FAULT_MRET_TGT   = 3'd4,
    FAULT_BRANCH_DEC = 3'd5
  } fault_cause_e;

  // IF to ID handover snapshot
  typedef struct packed {
    logic            hand;
    logic [PC_W-1:0] pc_if;
    logic [PC_W-1:0] pc_id;
    logic            compressed;
    logic            ptr;
    logic            dummy;
    logic            last_op;
  } if_id_t;

  typedef struct packed {
    logic            set;
    pc_mux_e         mux;
    logic [PC_W-1:0] target;
    logic            cmp_result;
  } pc_set_t;

  typedef struct packed {
    logic pc_hardening;
    logic dataindtiming;
  } cpuctrl_t;

  typedef struct packed {
    fault_cause_e    cause;
    logic [PC_W-1:0] pc;
  } fault_rec_t;

  // Secure defaults with hardening on
  localparam cpuctrl_t CPUCTRL_RST = '{pc_hardening: 1'b1, dataindtiming: 1'b0};

endpackage

`default_nettype wire

// File: hw/pc_xsecure_ctrl.sv
// Security control register
`default_nettype none
`timescale 1ns/1ps

module pc_xsecure_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cfg_we_i,
  input  pc_hard_pkg::cpuctrl_t cfg_wdata_i,
  output pc_hard_pkg::cpuctrl_t cpuctrl_o
);

  pc_hard_pkg::cpuctrl_t cpuctrl_q;

  // Register loads on a write strobe
  // New value visible the cycle after the write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cpuctrl_q <= pc_hard_pkg::CPUCTRL_RST;
    end else if (cfg_we_i) begin
      cpuctrl_q <= cfg_wdata_i;
    end
  end

  assign cpuctrl_o = cpuctrl_q;

  // Hardening must come out of reset enabled
  a_pc_hardening_default_on: assert property (
    @(posedge clk_i)
    $rose(rst_n_i) |-> cpuctrl_o.pc_hardening
  ) else $error("pc_hardening not set after reset release");

endmodule

`default_nettype wire

// File: hw/pc_seq_check.sv
// Sequential fetch PC checker
`default_nettype none
`timescale 1ns/1ps

module pc_seq_check (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  pc_hard_pkg::if_id_t     if_id_i,
  input  pc_hard_pkg::pc_set_t    pc_set_i,
  output pc_hard_pkg::fault_rec_t fault_o
);

  // Control state
  logic pend_q;
  logic seen_q;
  logic set_q;

  // Handover snapshot
  logic [pc_hard_pkg::PC_W-1:0] pc_id_q;
  logic [pc_hard_pkg::PC_W-1:0] pc_if_q;
  logic                         cmpr_q;
  logic                         dummy_q;
  logic                         last_op_q;

  logic [pc_hard_pkg::PC_W-1:0] pc_exp;
  logic                         exempt;
  logic                         mismatch;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
      seen_q <= 1'b0;
      set_q  <= 1'b0;
    end else begin
      // Check runs only in the cycle right after a handover
      pend_q <= if_id_i.hand;
      seen_q <= seen_q | if_id_i.hand;
      set_q  <= pc_set_i.set;
    end
  end

  always_ff @(posedge clk_i) begin
    if (if_id_i.hand) begin
      pc_id_q   <= if_id_i.pc_id;
      pc_if_q   <= if_id_i.pc_if;
      cmpr_q    <= if_id_i.compressed;
      dummy_q   <= if_id_i.dummy;
      last_op_q <= if_id_i.last_op;
    end
  end

  // Expected successor of the ID PC
  assign pc_exp = pc_id_q + (cmpr_q ? pc_hard_pkg::INC_CMPR : pc_hard_pkg::INC_FULL);

  // Exemptions
  // PC set now or one cycle ago, table pointer in IF, both PCs still zero
  assign exempt = pc_set_i.set | set_q | if_id_i.ptr |
                  ((if_id_i.pc_if == '0) && (pc_id_q == '0));

  always_comb begin
    if (dummy_q) begin
      // Dummy shares the PC of the instruction in ID
      mismatch = (if_id_i.pc_if != pc_id_q);
    end else if (!last_op_q) begin
      // Multi-op instruction keeps IF parked
      mismatch = (if_id_i.pc_if != pc_if_q);
    end else begin
      mismatch = (if_id_i.pc_if != pc_exp);
    end
  end

  always_comb begin
    fault_o.pc    = if_id_i.pc_if;
    fault_o.cause = pc_hard_pkg::FAULT_NONE;
    if (pend_q && !exempt && mismatch) begin
      fault_o.cause = pc_hard_pkg::FAULT_SEQ;
    end
  end

  // No sequence fault before the first handover
  a_no_fault_before_hand: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !seen_q |-> (fault_o.cause == pc_hard_pkg::FAULT_NONE)
  ) else $error("sequence fault without prior handover");

endmodule

`default_nettype wire

// File: hw/pc_target_check.sv
// PC-set target recomputation checker
`default_nettype none
`timescale 1ns/1ps

module pc_target_check (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  pc_hard_pkg::pc_set_t    pc_set_i,
  input  pc_hard_pkg::cpuctrl_t   cpuctrl_i,
  output pc_hard_pkg::fault_rec_t fault_o
);

  // Registered PC set, armed only for checked mux states
  logic                         pc_set_q;
  pc_hard_pkg::pc_mux_e         mux_q;
  logic [pc_hard_pkg::PC_W-1:0] tgt_q;
  logic                         cmp_q;

  logic checked_mux;
  logic tgt_diff;
  logic dec_diff;

  assign checked_mux = (pc_set_i.mux == pc_hard_pkg::PC_MUX_BRANCH) ||
                       (pc_set_i.mux == pc_hard_pkg::PC_MUX_JUMP) ||
                       (pc_set_i.mux == pc_hard_pkg::PC_MUX_MRET);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_set_q <= 1'b0;
    end else begin
      pc_set_q <= pc_set_i.set && checked_mux;
    end
  end

  // First computation
  always_ff @(posedge clk_i) begin
    if (pc_set_i.set) begin
      mux_q <= pc_set_i.mux;
      tgt_q <= pc_set_i.target;
      cmp_q <= pc_set_i.cmp_result;
    end
  end

  // Recomputation presented one cycle later
  assign tgt_diff = (pc_set_i.target != tgt_q);
  // Decision is fixed to taken under data independent timing
  assign dec_diff = (pc_set_i.cmp_result != cmp_q) && !cpuctrl_i.dataindtiming;

  always_comb begin
    fault_o.pc    = tgt_q;
    fault_o.cause = pc_hard_pkg::FAULT_NONE;
    if (pc_set_q) begin
      case (mux_q)
        pc_hard_pkg::PC_MUX_BRANCH: begin
          // Target mismatch wins over decision mismatch
          if (tgt_diff) begin
            fault_o.cause = pc_hard_pkg::FAULT_BRANCH_TGT;
          end else if (dec_diff) begin
            fault_o.cause = pc_hard_pkg::FAULT_BRANCH_DEC;
          end
        end
        pc_hard_pkg::PC_MUX_JUMP: begin
          if (tgt_diff) fault_o.cause = pc_hard_pkg::FAULT_JUMP_TGT;
        end
        pc_hard_pkg::PC_MUX_MRET: begin
          if (tgt_diff) fault_o.cause = pc_hard_pkg::FAULT_MRET_TGT;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/pc_alert_log.sv
// Major alert and fault record logger
`default_nettype none
`timescale 1ns/1ps

module pc_alert_log (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  pc_hard_pkg::cpuctrl_t   cpuctrl_i,
  input  pc_hard_pkg::fault_rec_t seq_fault_i,
  input  pc_hard_pkg::fault_rec_t tgt_fault_i,
  input  logic                    rec_credit_i,
  output logic                    alert_major_o,
  output logic                    rec_valid_o,
  output pc_hard_pkg::fault_rec_t rec_o,
  output logic                    rec_drop_o
);

  pc_hard_pkg::fault_rec_t mem_q [pc_hard_pkg::FIFO_DEPTH];

  logic [pc_hard_pkg::FIFO_AW-1:0] wr_ptr_q;
  logic [pc_hard_pkg::FIFO_AW-1:0] rd_ptr_q;
  logic [pc_hard_pkg::FIFO_CW-1:0] cnt_q;
  logic [pc_hard_pkg::FIFO_CW-1:0] cnt_d;
  logic [pc_hard_pkg::FIFO_CW-1:0] free;
  logic [pc_hard_pkg::CRED_W-1:0]  cred_q;
  logic [pc_hard_pkg::CRED_W-1:0]  cred_d;
  logic [1:0]                      n_req;
  logic                            seq_vld;
  logic                            tgt_vld;
  logic                            acc_first;
  logic                            acc_second;
  logic                            drop_now;
  logic                            pop;
  pc_hard_pkg::fault_rec_t         first_rec;

  // Hardening gate applies here only
  assign seq_vld = cpuctrl_i.pc_hardening && (seq_fault_i.cause != pc_hard_pkg::FAULT_NONE);
  assign tgt_vld = cpuctrl_i.pc_hardening && (tgt_fault_i.cause != pc_hard_pkg::FAULT_NONE);
  assign n_req   = {1'b0, seq_vld} + {1'b0, tgt_vld};

  // Target record takes the first slot
  assign first_rec = tgt_vld ? tgt_fault_i : seq_fault_i;

  // Space check ignores a same-cycle pop
  assign free       = pc_hard_pkg::FIFO_CNT_MAX - cnt_q;
  assign acc_first  = (n_req != 2'd0) && (free != '0);
  assign acc_second = (n_req == 2'd2) && (free[pc_hard_pkg::FIFO_CW-1:1] != '0);
  assign drop_now   = ((n_req != 2'd0) && !acc_first) || ((n_req == 2'd2) && !acc_second);

  // Send only with a credit in hand
  assign pop = (cnt_q != '0) && (cred_q != '0);

  always_comb begin
    cnt_d = cnt_q;
    if (acc_first) cnt_d = cnt_d + 1'b1;
    if (acc_second) cnt_d = cnt_d + 1'b1;
    if (pop) cnt_d = cnt_d - 1'b1;
  end

  always_comb begin
    cred_d = cred_q;
    if (pop) cred_d = cred_d - 1'b1;
    if (rec_credit_i) cred_d = cred_d + 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      alert_major_o <= 1'b0;
      rec_valid_o   <= 1'b0;
      rec_drop_o    <= 1'b0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      cnt_q         <= '0;
      cred_q        <= pc_hard_pkg::CRED_INIT;
    end else begin
      // One alert cycle per faulting cycle
      alert_major_o <= seq_vld | tgt_vld;
      rec_valid_o   <= pop;
      rec_drop_o    <= rec_drop_o | drop_now;
      wr_ptr_q      <= wr_ptr_q + {1'b0, acc_first} + {1'b0, acc_second};
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q         <= cnt_d;
      cred_q        <= cred_d;
    end
  end

  // Queue storage and outgoing payload
  always_ff @(posedge clk_i) begin
    if (acc_first) mem_q[wr_ptr_q] <= first_rec;
    if (acc_second) mem_q[wr_ptr_q + 1'b1] <= seq_fault_i;
    if (pop) rec_o <= mem_q[rd_ptr_q];
  end

  a_rec_needs_credit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rec_valid_o |-> $past(cred_q != '0)
  ) else $error("record sent without credit");

  a_cred_bound: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cred_q <= pc_hard_pkg::CRED_INIT
  ) else $error("credit counter above grant");

endmodule

`default_nettype wire

// File: hw/pc_hardening_top.sv
// PC hardening checker top
`default_nettype none
`timescale 1ns/1ps

module pc_hardening_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cfg_we_i,
  input  pc_hard_pkg::cpuctrl_t   cfg_wdata_i,
  input  pc_hard_pkg::if_id_t     if_id_i,
  input  pc_hard_pkg::pc_set_t    pc_set_i,
  input  logic                    rec_credit_i,
  output logic                    alert_major_o,
  output logic                    rec_valid_o,
  output pc_hard_pkg::fault_rec_t rec_o,
  output logic                    rec_drop_o
);

  pc_hard_pkg::cpuctrl_t   cpuctrl;
  pc_hard_pkg::fault_rec_t seq_fault;
  pc_hard_pkg::fault_rec_t tgt_fault;

  // Control register
  pc_xsecure_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cpuctrl_o   (cpuctrl)
  );

  // Fetch order checker
  pc_seq_check u_seq (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .if_id_i  (if_id_i),
    .pc_set_i (pc_set_i),
    .fault_o  (seq_fault)
  );

  // Target and decision recomputation checker
  pc_target_check u_tgt (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .pc_set_i  (pc_set_i),
    .cpuctrl_i (cpuctrl),
    .fault_o   (tgt_fault)
  );

  // Alert and record output
  pc_alert_log u_log (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cpuctrl_i     (cpuctrl),
    .seq_fault_i   (seq_fault),
    .tgt_fault_i   (tgt_fault),
    .rec_credit_i  (rec_credit_i),
    .alert_major_o (alert_major_o),
    .rec_valid_o   (rec_valid_o),
    .rec_o         (rec_o),
    .rec_drop_o    (rec_drop_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_pc_hardening_top.sv
// PC hardening testbench
`default_nettype none
`timescale 1ns/1ps

module tb_pc_hardening_top;

  localparam int NUM_TESTS = 6;
  localparam int WAIT_MAX  = 32;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    cfg_we_i;
  pc_hard_pkg::cpuctrl_t   cfg_wdata_i;
  pc_hard_pkg::if_id_t     if_id_i;
  pc_hard_pkg::pc_set_t    pc_set_i;
  logic                    rec_credit_i;
  logic                    alert_major_o;
  logic                    rec_valid_o;
  pc_hard_pkg::fault_rec_t rec_o;
  logic                    rec_drop_o;

  // Effective control bits as the DUT should hold them
  pc_hard_pkg::cpuctrl_t   cfg_model;
  // Records seen on the output, oldest first
  pc_hard_pkg::fault_rec_t rec_q[$];
  int seed = 37941;
  int errors = 0;
  int errors_at_start = 0;
  int tests_run = 0;
  int tests_failed = 0;

  pc_hardening_top dut0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .if_id_i       (if_id_i),
    .pc_set_i      (pc_set_i),
    .rec_credit_i  (rec_credit_i),
    .alert_major_o (alert_major_o),
    .rec_valid_o   (rec_valid_o),
    .rec_o         (rec_o),
    .rec_drop_o    (rec_drop_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Sample sent records mid-cycle
  always @(negedge clk_i) begin
    if (rec_valid_o) rec_q.push_back(rec_o);
  end

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, tests did not finish", NUM_TESTS * 200);
    $display("Simulation failed");
    $finish;
  end

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_inputs();
    cfg_we_i     = 1'b0;
    if_id_i      = '0;
    pc_set_i.set = 1'b0;
    rec_credit_i = 1'b0;
  endtask

  // Sequential successor, 2 for compressed and 4 for full
  function automatic logic [31:0] succ(input logic [31:0] p, input logic c);
    return p + (c ? 32'd2 : 32'd4);
  endfunction

  // Word aligned and never zero
  function automatic logic [31:0] rand_pc();
    logic [31:0] v;
    v = $random(seed);
    return (v & 32'hFFFF_FFFC) | 32'h0000_1000;
  endfunction

  // Target mismatch wins, decision only checked without data independent timing
  function automatic pc_hard_pkg::fault_cause_e exp_tgt_cause(
    input pc_hard_pkg::pc_mux_e mux, input logic [31:0] a, input logic [31:0] a2,
    input logic c1, input logic c2);
    if (a != a2) begin
      case (mux)
        pc_hard_pkg::PC_MUX_BRANCH: return pc_hard_pkg::FAULT_BRANCH_TGT;
        pc_hard_pkg::PC_MUX_JUMP:   return pc_hard_pkg::FAULT_JUMP_TGT;
        pc_hard_pkg::PC_MUX_MRET:   return pc_hard_pkg::FAULT_MRET_TGT;
        default:                    return pc_hard_pkg::FAULT_NONE;
      endcase
    end
    if (mux == pc_hard_pkg::PC_MUX_BRANCH && c1 != c2 && !cfg_model.dataindtiming) begin
      return pc_hard_pkg::FAULT_BRANCH_DEC;
    end
    return pc_hard_pkg::FAULT_NONE;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED, %0d errors", tests_run, name, errors - errors_at_start);
    end
  endtask

  task automatic write_cfg(input logic hard, input logic dit);
    cfg_we_i    = 1'b1;
    cfg_wdata_i = '{pc_hardening: hard, dataindtiming: dit};
    step();
    cfg_we_i  = 1'b0;
    cfg_model = cfg_wdata_i;
  endtask

  // Called with the second event cycle driven, alert lands one edge later
  task automatic finish_event(input logic exp_alert);
    step();
    check_val("alert_major_o", 32'(alert_major_o), 32'(exp_alert));
    idle_inputs();
    step();
    check_val("alert_major_o", 32'(alert_major_o), 32'(1'b0));
  endtask

  task automatic take_record(input pc_hard_pkg::fault_cause_e cause, input logic [31:0] pc,
                             input logic give_credit);
    pc_hard_pkg::fault_rec_t rec;
    int waited;
    waited = 0;
    while (rec_q.size() == 0 && waited < WAIT_MAX) begin
      step();
      waited++;
    end
    assert (rec_q.size() != 0) else begin
      $display("No fault record arrived within %0d cycles", WAIT_MAX);
      errors++;
    end
    if (rec_q.size() != 0) begin
      rec = rec_q.pop_front();
      check_val("rec_o.cause", 32'(rec.cause), 32'(cause));
      check_val("rec_o.pc", rec.pc, pc);
      if (give_credit) begin
        rec_credit_i = 1'b1;
        step();
        rec_credit_i = 1'b0;
      end
    end
  endtask

  task automatic no_record(input int cycles);
    repeat (cycles) step();
    assert (rec_q.size() == 0) else begin
      $display("Unexpected fault record sent, %0d in queue", rec_q.size());
      errors++;
    end
    rec_q.delete();
  endtask

  // Handover of p, then a fetch PC that is not its successor
  task automatic seq_glitch(input logic [31:0] p, input logic c, input logic wr_off);
    logic [31:0] bad;
    logic        exp_alert;
    bad                = succ(p, c) + 32'h10;
    if_id_i            = '0;
    if_id_i.hand       = 1'b1;
    if_id_i.pc_if      = p;
    if_id_i.pc_id      = p;
    if_id_i.compressed = c;
    if_id_i.last_op    = 1'b1;
    if (wr_off) begin
      cfg_we_i    = 1'b1;
      cfg_wdata_i = '{pc_hardening: 1'b0, dataindtiming: cfg_model.dataindtiming};
    end
    step();
    if (wr_off) begin
      cfg_we_i  = 1'b0;
      cfg_model = cfg_wdata_i;
    end
    check_val("alert_major_o", 32'(alert_major_o), 32'(1'b0));
    if_id_i       = '0;
    if_id_i.pc_if = bad;
    exp_alert     = cfg_model.pc_hardening;
    finish_event(exp_alert);
    if (exp_alert) take_record(pc_hard_pkg::FAULT_SEQ, bad, 1'b1);
    else no_record(8);
  endtask

  // PC set with a, recomputation presents a2 and c2 one cycle later
  task automatic target_event(input pc_hard_pkg::pc_mux_e mux, input logic [31:0] a,
                              input logic [31:0] a2, input logic c1, input logic c2);
    pc_hard_pkg::fault_cause_e exp_cause;
    logic                      exp_alert;
    exp_cause  = exp_tgt_cause(mux, a, a2, c1, c2);
    exp_alert  = (exp_cause != pc_hard_pkg::FAULT_NONE) && cfg_model.pc_hardening;
    pc_set_i   = '{set: 1'b1, mux: mux, target: a, cmp_result: c1};
    step();
    check_val("alert_major_o", 32'(alert_major_o), 32'(1'b0));
    pc_set_i   = '{set: 1'b0, mux: mux, target: a2, cmp_result: c2};
    finish_event(exp_alert);
    if (exp_alert) take_record(exp_cause, a, 1'b1);
    else no_record(8);
  endtask

  task automatic test_reset_cfg();
    start_test();
    check_val("alert_major_o", 32'(alert_major_o), 32'(1'b0));
    check_val("rec_valid_o", 32'(rec_valid_o), 32'(1'b0));
    check_val("rec_drop_o", 32'(rec_drop_o), 32'(1'b0));
    // Hardening cleared in the handover cycle gates the fault one cycle later
    seq_glitch(rand_pc(), 1'b0, 1'b1);
    write_cfg(1'b1, 1'b0);
    end_test("reset defaults and configuration");
  endtask

  task automatic test_seq_flow();
    logic [31:0] nxt;
    int unsigned r;
    int          kind;
    logic        prev_set;
    start_test();
    nxt      = rand_pc();
    prev_set = 1'b0;
    for (int i = 0; i < 48; i++) begin
      r            = $random(seed);
      kind         = int'(r % 6);
      if_id_i      = '0;
      pc_set_i.set = 1'b0;
      // No back to back PC sets, the target would not match its recomputation
      if (kind == 5 && prev_set) kind = 0;
      if (kind != 2) begin
        if_id_i.hand    = 1'b1;
        if_id_i.pc_id   = nxt;
        if_id_i.last_op = 1'b1;
      end
      if_id_i.pc_if = nxt;
      case (kind)
        0, 1: begin
          if_id_i.compressed = r[8];
          nxt                = succ(nxt, r[8]);
        end
        // Multi-op instruction holds the fetch PC
        3: if_id_i.last_op = 1'b0;
        // Dummy keeps the PC of the instruction in ID
        4: if_id_i.dummy = 1'b1;
        // Jump handed to ID redirects fetch to a new target
        5: begin
          nxt           = rand_pc();
          if_id_i.pc_if = '0;
          pc_set_i      = '{set: 1'b1, mux: pc_hard_pkg::PC_MUX_JUMP, target: nxt,
                            cmp_result: 1'b0};
        end
        default: ;
      endcase
      prev_set = (kind == 5);
      step();
      check_val("alert_major_o", 32'(alert_major_o), 32'(1'b0));
    end
    // Fetch stalls on the last expected PC before the inputs go idle
    if_id_i       = '0;
    if_id_i.pc_if = nxt;
    pc_set_i.set  = 1'b0;
    step();
    check_val("alert_major_o", 32'(alert_major_o), 32'(1'b0));
    idle_inputs();
    repeat (3) begin
      step();
      check_val("alert_major_o", 32'(alert_major_o), 32'(1'b0));
    end
    no_record(4);
    end_test("sequential flow");
  endtask

  task automatic test_seq_glitch();
    start_test();
    seq_glitch(rand_pc(), 1'b0, 1'b0);
    seq_glitch(rand_pc(), 1'b1, 1'b0);
    write_cfg(1'b0, 1'b0);
    seq_glitch(rand_pc(), 1'b1, 1'b0);
    write_cfg(1'b1, 1'b0);
    end_test("PC glitch with hardening on and off");
  endtask

  task automatic test_target();
    pc_hard_pkg::pc_mux_e muxes [3];
    logic [31:0]          a;
    logic [31:0]          off;
    start_test();
    muxes = '{pc_hard_pkg::PC_MUX_BRANCH, pc_hard_pkg::PC_MUX_JUMP, pc_hard_pkg::PC_MUX_MRET};
    for (int m = 0; m < 3; m++) begin
      a   = rand_pc();
      off = $random(seed);
      off = (off & 32'h0000_FFFC) | 32'h4;
      target_event(muxes[m], a, a + off, 1'b1, 1'b1);
      target_event(muxes[m], a, a, 1'b1, 1'b1);
    end
    end_test("target recomputation");
  endtask

  task automatic test_branch_dec();
    logic [31:0] a;
    start_test();
    a = rand_pc();
    target_event(pc_hard_pkg::PC_MUX_BRANCH, a, a, 1'b0, 1'b1);
    target_event(pc_hard_pkg::PC_MUX_BRANCH, a, a + 32'h8, 1'b1, 1'b0);
    write_cfg(1'b1, 1'b1);
    target_event(pc_hard_pkg::PC_MUX_BRANCH, a, a, 1'b0, 1'b1);
    write_cfg(1'b1, 1'b0);
    end_test("branch decision");
  endtask

  task automatic test_credits();
    logic [31:0] base;
    start_test();
    base = rand_pc();
    rec_q.delete();
    // Two records use up the credits, four fill the FIFO, the last one is dropped
    for (int k = 0; k < 7; k++) begin
      check_val("rec_drop_o", 32'(rec_drop_o), 32'(1'b0));
      pc_set_i = '{set: 1'b1, mux: pc_hard_pkg::PC_MUX_JUMP, target: base + 32'(k * 16),
                   cmp_result: 1'b0};
      step();
      pc_set_i.set    = 1'b0;
      pc_set_i.target = base + 32'(k * 16) + 32'h4;
      step();
    end
    check_val("rec_drop_o", 32'(rec_drop_o), 32'(1'b1));
    idle_inputs();
    repeat (4) step();
    check_val("records sent without credit return", 32'(rec_q.size()), 32'(2));
    take_record(pc_hard_pkg::FAULT_JUMP_TGT, base, 1'b0);
    take_record(pc_hard_pkg::FAULT_JUMP_TGT, base + 32'h10, 1'b0);
    rec_credit_i = 1'b1;
    repeat (4) step();
    rec_credit_i = 1'b0;
    for (int k = 2; k < 6; k++) begin
      take_record(pc_hard_pkg::FAULT_JUMP_TGT, base + 32'(k * 16), 1'b0);
    end
    no_record(6);
    check_val("rec_drop_o", 32'(rec_drop_o), 32'(1'b1));
    end_test("credits and overflow");
  endtask

  initial begin
    rst_n_i      = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_wdata_i  = '0;
    if_id_i      = '0;
    pc_set_i     = '0;
    rec_credit_i = 1'b0;
    cfg_model    = '{pc_hardening: 1'b1, dataindtiming: 1'b0};
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    step();
    test_reset_cfg();
    test_seq_flow();
    test_seq_glitch();
    test_target();
    test_branch_dec();
    test_credits();
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: pc_hardening_top.f
hw/pc_hard_pkg.sv
hw/pc_xsecure_ctrl.sv
hw/pc_seq_check.sv
hw/pc_target_check.sv
hw/pc_alert_log.sv
hw/pc_hardening_top.sv
testbench/tb_pc_hardening_top.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_pc_hardening_top
RTL_TOP   ?= pc_hardening_top
FILELIST  ?= pc_hardening_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= hw/pc_hard_pkg.sv hw/pc_xsecure_ctrl.sv hw/pc_seq_check.sv \
             hw/pc_target_check.sv hw/pc_alert_log.sv hw/pc_hardening_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx "Simulation completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --assert --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
